// ==== source/apb_reg_pkg.sv ====
/* Register map of the memory-copy peripheral
   APB offsets and bit positions of the control and status fields */

package apb_reg_pkg;

  // APB address width, offsets are byte addresses
  localparam int REG_ADDR_WIDTH = 5;

  localparam logic [REG_ADDR_WIDTH-1:0] SRC_ADDR_OFFSET = 5'h00;
  localparam logic [REG_ADDR_WIDTH-1:0] DST_ADDR_OFFSET = 5'h04;
  localparam logic [REG_ADDR_WIDTH-1:0] SIZE_OFFSET     = 5'h08;
  localparam logic [REG_ADDR_WIDTH-1:0] CTRL_OFFSET     = 5'h0C;
  localparam logic [REG_ADDR_WIDTH-1:0] STATUS_OFFSET   = 5'h10;

  // CTRL fields
  // START is write-only and reads back as zero
  localparam int START_BIT   = 0;
  localparam int INTR_EN_BIT = 1;

  // STATUS fields
  localparam int BUSY_BIT = 0;
  // Sticky, write 1 to clear
  localparam int DONE_BIT = 1;

  // Word count held in SIZE
  localparam int SIZE_WIDTH = 16;

endpackage

// ==== source/obi_mem_pkg.sv ====
/* Bus widths of the OBI memory path
   Shared by the copy engine, the arbiter and the slow memory */

package obi_mem_pkg;

  // Data word on the bus
  localparam int DATA_WIDTH = 32;

  // Byte address, the low two bits are ignored
  // since every access is a full aligned word
  localparam int ADDR_WIDTH = 32;

endpackage

// ==== source/memcopy_regs.sv ====
/* Memory-copy register block on APB
   Holds the copy configuration, busy and done status and drives the interrupt */

module memcopy_regs (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  psel_i,
  input  logic                                  penable_i,
  input  logic                                  pwrite_i,
  input  logic [apb_reg_pkg::REG_ADDR_WIDTH-1:0] paddr_i,
  input  logic [31:0]                           pwdata_i,
  output logic [31:0]                           prdata_o,
  output logic                                  pslverr_o,
  output logic [obi_mem_pkg::ADDR_WIDTH-1:0]    src_addr_o,
  output logic [obi_mem_pkg::ADDR_WIDTH-1:0]    dst_addr_o,
  output logic [apb_reg_pkg::SIZE_WIDTH-1:0]    size_o,
  output logic                                  start_o,
  input  logic                                  done_i,
  output logic                                  intr_o
);

  logic                                 access;
  logic                                 wr_en;
  logic                                 hit;
  logic                                 clr_done;
  logic [obi_mem_pkg::ADDR_WIDTH-1:0]   src_addr_q;
  logic [obi_mem_pkg::ADDR_WIDTH-1:0]   dst_addr_q;
  logic [apb_reg_pkg::SIZE_WIDTH-1:0]   size_q;
  logic                                 intr_en_q;
  logic                                 busy_q;
  logic                                 done_q;

  // Second cycle of the transfer
  assign access = psel_i & penable_i;
  assign wr_en  = access & pwrite_i;

  // Read mux and address decode
  always_comb begin
    hit      = 1'b1;
    prdata_o = '0;
    case (paddr_i)
      apb_reg_pkg::SRC_ADDR_OFFSET: prdata_o = 32'(src_addr_q);
      apb_reg_pkg::DST_ADDR_OFFSET: prdata_o = 32'(dst_addr_q);
      apb_reg_pkg::SIZE_OFFSET:     prdata_o = 32'(size_q);
      apb_reg_pkg::CTRL_OFFSET:     prdata_o[apb_reg_pkg::INTR_EN_BIT] = intr_en_q;
      apb_reg_pkg::STATUS_OFFSET: begin
        prdata_o[apb_reg_pkg::BUSY_BIT] = busy_q;
        prdata_o[apb_reg_pkg::DONE_BIT] = done_q;
      end
      default: hit = 1'b0;
    endcase
  end

  assign pslverr_o = access & ~hit;

  // A start while busy is dropped here
  assign start_o = wr_en & (paddr_i == apb_reg_pkg::CTRL_OFFSET)
                 & pwdata_i[apb_reg_pkg::START_BIT] & ~busy_q;

  assign clr_done = wr_en & (paddr_i == apb_reg_pkg::STATUS_OFFSET)
                  & pwdata_i[apb_reg_pkg::DONE_BIT];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      src_addr_q <= '0;
      dst_addr_q <= '0;
      size_q     <= '0;
      intr_en_q  <= 1'b0;
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      if (wr_en) begin
        case (paddr_i)
          apb_reg_pkg::SRC_ADDR_OFFSET:
            src_addr_q <= pwdata_i[obi_mem_pkg::ADDR_WIDTH-1:0];
          apb_reg_pkg::DST_ADDR_OFFSET:
            dst_addr_q <= pwdata_i[obi_mem_pkg::ADDR_WIDTH-1:0];
          apb_reg_pkg::SIZE_OFFSET:
            size_q <= pwdata_i[apb_reg_pkg::SIZE_WIDTH-1:0];
          apb_reg_pkg::CTRL_OFFSET:
            intr_en_q <= pwdata_i[apb_reg_pkg::INTR_EN_BIT];
          default: ;
        endcase
      end
      if (start_o) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
      // Completion wins over a clear in the same cycle
      if (done_i) begin
        done_q <= 1'b1;
      end else if (clr_done) begin
        done_q <= 1'b0;
      end
    end
  end

  assign src_addr_o = src_addr_q;
  assign dst_addr_o = dst_addr_q;
  assign size_o     = size_q;
  assign intr_o     = done_q & intr_en_q;

endmodule

// ==== source/memcopy_engine.sv ====
/* Memory-copy engine, an OBI master
   Reads each source word and writes it to the destination in ascending order */

module memcopy_engine (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               start_i,
  input  logic [obi_mem_pkg::ADDR_WIDTH-1:0] src_addr_i,
  input  logic [obi_mem_pkg::ADDR_WIDTH-1:0] dst_addr_i,
  input  logic [apb_reg_pkg::SIZE_WIDTH-1:0] size_i,
  output logic                               done_o,
  output logic                               eng_req_o,
  output logic                               eng_we_o,
  output logic [obi_mem_pkg::ADDR_WIDTH-1:0] eng_addr_o,
  output logic [obi_mem_pkg::DATA_WIDTH-1:0] eng_wdata_o,
  input  logic                               eng_gnt_i,
  input  logic                               eng_rvalid_i,
  input  logic [obi_mem_pkg::DATA_WIDTH-1:0] eng_rdata_i
);

  localparam logic [2:0] ST_IDLE    = 3'd0;
  localparam logic [2:0] ST_RD_REQ  = 3'd1;
  localparam logic [2:0] ST_RD_WAIT = 3'd2;
  localparam logic [2:0] ST_WR_REQ  = 3'd3;
  localparam logic [2:0] ST_WR_WAIT = 3'd4;

  localparam logic [obi_mem_pkg::ADDR_WIDTH-1:0] WORD_BYTES = 4;

  logic [2:0]                         state_q;
  logic                               done_q;
  logic [obi_mem_pkg::ADDR_WIDTH-1:0] src_q;
  logic [obi_mem_pkg::ADDR_WIDTH-1:0] dst_q;
  logic [apb_reg_pkg::SIZE_WIDTH-1:0] count_q;
  logic [obi_mem_pkg::DATA_WIDTH-1:0] data_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            // Empty copy finishes straight away
            if (size_i == '0) begin
              done_q <= 1'b1;
            end else begin
              state_q <= ST_RD_REQ;
            end
          end
        end
        ST_RD_REQ: begin
          if (eng_gnt_i) begin
            state_q <= ST_RD_WAIT;
          end
        end
        ST_RD_WAIT: begin
          if (eng_rvalid_i) begin
            state_q <= ST_WR_REQ;
          end
        end
        ST_WR_REQ: begin
          if (eng_gnt_i) begin
            state_q <= ST_WR_WAIT;
          end
        end
        ST_WR_WAIT: begin
          if (eng_rvalid_i) begin
            if (count_q == apb_reg_pkg::SIZE_WIDTH'(1)) begin
              done_q  <= 1'b1;
              state_q <= ST_IDLE;
            end else begin
              state_q <= ST_RD_REQ;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Copy pointers, count and the word in flight
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && start_i) begin
      src_q   <= src_addr_i;
      dst_q   <= dst_addr_i;
      count_q <= size_i;
    end
    if (state_q == ST_RD_WAIT && eng_rvalid_i) begin
      data_q <= eng_rdata_i;
    end
    if (state_q == ST_WR_WAIT && eng_rvalid_i) begin
      src_q   <= src_q + WORD_BYTES;
      dst_q   <= dst_q + WORD_BYTES;
      count_q <= count_q - apb_reg_pkg::SIZE_WIDTH'(1);
    end
  end

  assign eng_req_o   = (state_q == ST_RD_REQ) || (state_q == ST_WR_REQ);
  assign eng_we_o    = (state_q == ST_WR_REQ);
  assign eng_addr_o  = (state_q == ST_WR_REQ) ? dst_q : src_q;
  assign eng_wdata_o = data_q;
  assign done_o      = done_q;

endmodule

// ==== source/obi_arbiter.sv ====
/* Round-robin arbiter for two OBI masters on one memory port
   One transaction in flight, response steered back to its owner */

module obi_arbiter (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               m0_req_i,
  input  logic                               m0_we_i,
  input  logic [obi_mem_pkg::ADDR_WIDTH-1:0] m0_addr_i,
  input  logic [obi_mem_pkg::DATA_WIDTH-1:0] m0_wdata_i,
  output logic                               m0_gnt_o,
  output logic                               m0_rvalid_o,
  output logic [obi_mem_pkg::DATA_WIDTH-1:0] m0_rdata_o,
  input  logic                               m1_req_i,
  input  logic                               m1_we_i,
  input  logic [obi_mem_pkg::ADDR_WIDTH-1:0] m1_addr_i,
  input  logic [obi_mem_pkg::DATA_WIDTH-1:0] m1_wdata_i,
  output logic                               m1_gnt_o,
  output logic                               m1_rvalid_o,
  output logic [obi_mem_pkg::DATA_WIDTH-1:0] m1_rdata_o,
  output logic                               mem_req_o,
  output logic                               mem_we_o,
  output logic [obi_mem_pkg::ADDR_WIDTH-1:0] mem_addr_o,
  output logic [obi_mem_pkg::DATA_WIDTH-1:0] mem_wdata_o,
  input  logic                               mem_gnt_i,
  input  logic                               mem_rvalid_i,
  input  logic [obi_mem_pkg::DATA_WIDTH-1:0] mem_rdata_i
);

  logic prio_q;   // master favoured on a tie
  logic lock_q;   // request shown to memory, waiting for gnt
  logic pend_q;   // granted, waiting for rvalid
  logic owner_q;
  logic rr_sel;
  logic sel;

  assign rr_sel = (m0_req_i && m1_req_i) ? prio_q : m1_req_i;
  // Selection is frozen from the first request cycle until rvalid
  assign sel    = (lock_q || pend_q) ? owner_q : rr_sel;

  assign mem_req_o   = ~pend_q & (sel ? m1_req_i : m0_req_i);
  assign mem_we_o    = sel ? m1_we_i : m0_we_i;
  assign mem_addr_o  = sel ? m1_addr_i : m0_addr_i;
  assign mem_wdata_o = sel ? m1_wdata_i : m0_wdata_i;

  assign m0_gnt_o = mem_gnt_i & mem_req_o & ~sel;
  assign m1_gnt_o = mem_gnt_i & mem_req_o & sel;

  assign m0_rvalid_o = mem_rvalid_i & pend_q & ~owner_q;
  assign m1_rvalid_o = mem_rvalid_i & pend_q & owner_q;
  assign m0_rdata_o  = owner_q ? '0 : mem_rdata_i;
  assign m1_rdata_o  = owner_q ? mem_rdata_i : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_q  <= 1'b0;
      lock_q  <= 1'b0;
      pend_q  <= 1'b0;
      owner_q <= 1'b0;
    end else begin
      if (mem_req_o) begin
        owner_q <= sel;
        if (mem_gnt_i) begin
          lock_q <= 1'b0;
          pend_q <= 1'b1;
          prio_q <= ~sel;
        end else begin
          lock_q <= 1'b1;
        end
      end else if (pend_q && mem_rvalid_i) begin
        pend_q <= 1'b0;
      end
    end
  end

endmodule

// ==== source/slow_memory.sv ====
/* Slow word memory on an OBI slave port
   Grant held back by a fixed number of cycles, read data one cycle after grant */

module slow_memory #(
  parameter int NUM_WORDS = 128,
  parameter int GNT_DELAY = 3
) (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               req_i,
  input  logic                               we_i,
  input  logic [obi_mem_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [obi_mem_pkg::DATA_WIDTH-1:0] wdata_i,
  output logic                               gnt_o,
  output logic                               rvalid_o,
  output logic [obi_mem_pkg::DATA_WIDTH-1:0] rdata_o
);

  localparam int IDX_W = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;
  localparam int CNT_W = (GNT_DELAY > 0) ? $clog2(GNT_DELAY + 1) : 1;

  logic [obi_mem_pkg::DATA_WIDTH-1:0] mem_q [NUM_WORDS];
  logic [obi_mem_pkg::ADDR_WIDTH-3:0] word_addr;
  logic [IDX_W-1:0]                   idx;
  logic [CNT_W-1:0]                   wait_q;
  logic                               rvalid_q;
  logic [obi_mem_pkg::DATA_WIDTH-1:0] rdata_q;

  // Word index wraps around the memory size
  assign word_addr = addr_i[obi_mem_pkg::ADDR_WIDTH-1:2];
  assign idx       = IDX_W'(word_addr % NUM_WORDS);

  assign gnt_o = req_i & (wait_q == CNT_W'(GNT_DELAY));

  // Wait counter restarts whenever req drops or a grant is given
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wait_q   <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt_o;
      if (!req_i || gnt_o) begin
        wait_q <= '0;
      end else begin
        wait_q <= wait_q + CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      if (we_i) begin
        mem_q[idx] <= wdata_i;
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

// ==== source/ext_device_top.sv ====
/* External device example with a memory-copy peripheral and slow memory
   APB registers feed the copy engine, which shares the memory with the ext port */

module ext_device_top #(
  parameter int NUM_WORDS = 128,
  parameter int GNT_DELAY = 3
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  psel_i,
  input  logic                                  penable_i,
  input  logic                                  pwrite_i,
  input  logic [apb_reg_pkg::REG_ADDR_WIDTH-1:0] paddr_i,
  input  logic [31:0]                           pwdata_i,
  output logic [31:0]                           prdata_o,
  output logic                                  pslverr_o,
  input  logic                                  ext_req_i,
  input  logic                                  ext_we_i,
  input  logic [obi_mem_pkg::ADDR_WIDTH-1:0]    ext_addr_i,
  input  logic [obi_mem_pkg::DATA_WIDTH-1:0]    ext_wdata_i,
  output logic                                  ext_gnt_o,
  output logic                                  ext_rvalid_o,
  output logic [obi_mem_pkg::DATA_WIDTH-1:0]    ext_rdata_o,
  output logic                                  intr_o
);

  logic [obi_mem_pkg::ADDR_WIDTH-1:0] src_addr;
  logic [obi_mem_pkg::ADDR_WIDTH-1:0] dst_addr;
  logic [apb_reg_pkg::SIZE_WIDTH-1:0] size;
  logic                               start;
  logic                               done;

  logic                               eng_req;
  logic                               eng_we;
  logic [obi_mem_pkg::ADDR_WIDTH-1:0] eng_addr;
  logic [obi_mem_pkg::DATA_WIDTH-1:0] eng_wdata;
  logic                               eng_gnt;
  logic                               eng_rvalid;
  logic [obi_mem_pkg::DATA_WIDTH-1:0] eng_rdata;

  logic                               mem_req;
  logic                               mem_we;
  logic [obi_mem_pkg::ADDR_WIDTH-1:0] mem_addr;
  logic [obi_mem_pkg::DATA_WIDTH-1:0] mem_wdata;
  logic                               mem_gnt;
  logic                               mem_rvalid;
  logic [obi_mem_pkg::DATA_WIDTH-1:0] mem_rdata;

  memcopy_regs regs0 (
    .clk_i, .reset_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pslverr_o,
    .src_addr_o (src_addr),
    .dst_addr_o (dst_addr),
    .size_o     (size),
    .start_o    (start),
    .done_i     (done),
    .intr_o
  );

  memcopy_engine engine0 (
    .clk_i, .reset_i,
    .start_i      (start),
    .src_addr_i   (src_addr),
    .dst_addr_i   (dst_addr),
    .size_i       (size),
    .done_o       (done),
    .eng_req_o    (eng_req),
    .eng_we_o     (eng_we),
    .eng_addr_o   (eng_addr),
    .eng_wdata_o  (eng_wdata),
    .eng_gnt_i    (eng_gnt),
    .eng_rvalid_i (eng_rvalid),
    .eng_rdata_i  (eng_rdata)
  );

  // Engine on port 0, external master on port 1
  obi_arbiter arb0 (
    .clk_i, .reset_i,
    .m0_req_i (eng_req), .m0_we_i (eng_we), .m0_addr_i (eng_addr),
    .m0_wdata_i (eng_wdata), .m0_gnt_o (eng_gnt), .m0_rvalid_o (eng_rvalid),
    .m0_rdata_o (eng_rdata),
    .m1_req_i (ext_req_i), .m1_we_i (ext_we_i), .m1_addr_i (ext_addr_i),
    .m1_wdata_i (ext_wdata_i), .m1_gnt_o (ext_gnt_o), .m1_rvalid_o (ext_rvalid_o),
    .m1_rdata_o (ext_rdata_o),
    .mem_req_o (mem_req), .mem_we_o (mem_we), .mem_addr_o (mem_addr),
    .mem_wdata_o (mem_wdata), .mem_gnt_i (mem_gnt), .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i (mem_rdata)
  );

  slow_memory #(
    .NUM_WORDS (NUM_WORDS),
    .GNT_DELAY (GNT_DELAY)
  ) mem0 (
    .clk_i, .reset_i,
    .req_i    (mem_req),
    .we_i     (mem_we),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .gnt_o    (mem_gnt),
    .rvalid_o (mem_rvalid),
    .rdata_o  (mem_rdata)
  );

endmodule

// ==== sim/ext_device_assertions.sv ====
/* Protocol checks on the APB port and the OBI paths of the external device
   Bound into ext_device_top */

module ext_device_assertions (
  input logic                               clk_i,
  input logic                               reset_i,
  input logic                               psel_i,
  input logic                               penable_i,
  input logic                               ext_req_i,
  input logic                               ext_we_i,
  input logic [obi_mem_pkg::ADDR_WIDTH-1:0] ext_addr_i,
  input logic [obi_mem_pkg::DATA_WIDTH-1:0] ext_wdata_i,
  input logic                               ext_gnt_o,
  input logic                               ext_rvalid_o,
  input logic                               eng_req,
  input logic                               eng_we,
  input logic [obi_mem_pkg::ADDR_WIDTH-1:0] eng_addr,
  input logic [obi_mem_pkg::DATA_WIDTH-1:0] eng_wdata,
  input logic                               eng_gnt,
  input logic                               eng_rvalid,
  input logic                               mem_gnt
);

  // Request held steady until granted
  ext_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    ext_req_i && !ext_gnt_o |=> ext_req_i && $stable(ext_we_i)
      && $stable(ext_addr_i) && $stable(ext_wdata_i))
    else $error("ext request changed before its grant");

  eng_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    eng_req && !eng_gnt |=> eng_req && $stable(eng_we) && $stable(eng_addr) && $stable(eng_wdata))
    else $error("engine request changed before its grant");

  ext_rvalid_a: assert property (@(posedge clk_i) disable iff (reset_i)
    ext_rvalid_o |-> $past(ext_gnt_o))
    else $error("ext rvalid without a grant");

  eng_rvalid_a: assert property (@(posedge clk_i) disable iff (reset_i)
    eng_rvalid |-> $past(eng_gnt))
    else $error("engine rvalid without a grant");

  // Every memory grant goes back to a master that is requesting
  mem_gnt_a: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_gnt |-> (eng_req && eng_gnt) || (ext_req_i && ext_gnt_o))
    else $error("memory grant without a requesting master");

  apb_access_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(penable_i) |-> psel_i && $past(psel_i && !penable_i))
    else $error("APB penable without a setup cycle");

endmodule

bind ext_device_top ext_device_assertions asrt0 (
  .clk_i, .reset_i, .psel_i, .penable_i,
  .ext_req_i, .ext_we_i, .ext_addr_i, .ext_wdata_i, .ext_gnt_o, .ext_rvalid_o,
  .eng_req, .eng_we, .eng_addr, .eng_wdata, .eng_gnt, .eng_rvalid,
  .mem_gnt
);

// ==== sim/ext_device_tb.sv ====
/* Testbench for the external device example
   APB programs copies, the ext OBI port loads and inspects the memory */

module ext_device_tb;

  localparam int NUM_WORDS  = 128;
  localparam int MAX_LEN    = 16;
  localparam int MAX_CYCLES = 20000;

  localparam logic [31:0] START_MASK   = 32'd1 << apb_reg_pkg::START_BIT;
  localparam logic [31:0] INTR_EN_MASK = 32'd1 << apb_reg_pkg::INTR_EN_BIT;
  localparam logic [31:0] BUSY_MASK    = 32'd1 << apb_reg_pkg::BUSY_BIT;
  localparam logic [31:0] DONE_MASK    = 32'd1 << apb_reg_pkg::DONE_BIT;
  localparam logic [31:0] SIZE_MASK    = (32'd1 << apb_reg_pkg::SIZE_WIDTH) - 32'd1;

  logic                                   clk_i;
  logic                                   reset_i;
  logic                                   psel_i;
  logic                                   penable_i;
  logic                                   pwrite_i;
  logic [apb_reg_pkg::REG_ADDR_WIDTH-1:0] paddr_i;
  logic [31:0]                            pwdata_i;
  logic [31:0]                            prdata_o;
  logic                                   pslverr_o;
  logic                                   ext_req_i;
  logic                                   ext_we_i;
  logic [31:0]                            ext_addr_i;
  logic [31:0]                            ext_wdata_i;
  logic                                   ext_gnt_o;
  logic                                   ext_rvalid_o;
  logic [31:0]                            ext_rdata_o;
  logic                                   intr_o;

  logic [31:0] shadow [NUM_WORDS];
  string       name_q [$];
  logic [31:0] exp_q [$];
  logic [31:0] got_q [$];
  int          errors;
  int          checks;
  int          cycles;
  int          intr_rises;
  logic        intr_q;

  ext_device_top #(
    .NUM_WORDS (NUM_WORDS),
    .GNT_DELAY (3)
  ) dut0 (
    .clk_i, .reset_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pslverr_o, .ext_req_i, .ext_we_i, .ext_addr_i, .ext_wdata_i,
    .ext_gnt_o, .ext_rvalid_o, .ext_rdata_o, .intr_o
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: the test did not finish within %0d cycles", MAX_CYCLES);
    $display("%0d checks, %0d errors", checks, errors + 1);
    $display("Done: errors found");
    $finish;
  end

  // Counts completions seen on the interrupt line
  always @(posedge clk_i) begin
    if (reset_i) begin
      intr_q     <= 1'b0;
      intr_rises <= 0;
    end else begin
      intr_q <= intr_o;
      if (intr_o && !intr_q) begin
        intr_rises <= intr_rises + 1;
      end
    end
  end

  always @(negedge clk_i) begin : compare
    string       name;
    logic [31:0] exp_val;
    logic [31:0] got_val;
    while (exp_q.size() > 0) begin
      name    = name_q.pop_front();
      exp_val = exp_q.pop_front();
      got_val = got_q.pop_front();
      checks++;
      if (got_val !== exp_val) begin
        errors++;
        $display("error at time %0t: %s expected %h, got %h", $time, name, exp_val, got_val);
      end
    end
  end

  task automatic expect_value(input string name, input logic [31:0] exp_val,
                              input logic [31:0] got_val);
    name_q.push_back(name);
    exp_q.push_back(exp_val);
    got_q.push_back(got_val);
  endtask

  // Setup cycle, access cycle, response sampled at the end of access
  task automatic apb_xfer(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(posedge clk_i);
    rdata = prdata_o;
    err   = pslverr_o;
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic reg_write(input logic [4:0] addr, input logic [31:0] data);
    logic [31:0] d;
    logic        e;
    apb_xfer(1'b1, addr, data, d, e);
    expect_value("pslverr_o", 32'd0, 32'(e));
  endtask

  task automatic reg_check(input logic [4:0] addr, input logic [31:0] exp_val,
                           input string name);
    logic [31:0] d;
    logic        e;
    apb_xfer(1'b0, addr, 32'd0, d, e);
    expect_value(name, exp_val, d);
    expect_value("pslverr_o", 32'd0, 32'(e));
  endtask

  task automatic obi_access(input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge clk_i);
    ext_req_i   <= 1'b1;
    ext_we_i    <= we;
    ext_addr_i  <= addr;
    ext_wdata_i <= wdata;
    do @(posedge clk_i); while (!ext_gnt_o);
    ext_req_i <= 1'b0;
    do @(posedge clk_i); while (!ext_rvalid_o);
    rdata = ext_rdata_o;
  endtask

  // Copies ascending on the shadow image and returns the new destination words
  function automatic logic [MAX_LEN*32-1:0] ref_copy(input int src_w, input int dst_w,
                                                    input int len);
    logic [MAX_LEN*32-1:0] dst_words;
    dst_words = '0;
    for (int i = 0; i < len; i++) begin
      shadow[dst_w + i] = shadow[src_w + i];
      dst_words[i*32 +: 32] = shadow[dst_w + i];
    end
    return dst_words;
  endfunction

  task automatic verify_copy(input int src_w, input int dst_w, input int len);
    logic [MAX_LEN*32-1:0] exp_dst;
    logic [31:0]           r;
    exp_dst = ref_copy(src_w, dst_w, len);
    for (int i = 0; i < len; i++) begin
      obi_access(1'b0, 32'((dst_w + i) * 4), 32'd0, r);
      expect_value("ext_rdata_o", exp_dst[i*32 +: 32], r);
      obi_access(1'b0, 32'((src_w + i) * 4), 32'd0, r);
      expect_value("ext_rdata_o", shadow[src_w + i], r);
    end
  endtask

  task automatic run_copy(input int src_w, input int dst_w, input int len);
    logic [31:0] status;
    logic [31:0] r;
    logic [31:0] v;
    logic        e;
    logic        finished;
    int          w;
    reg_write(apb_reg_pkg::SRC_ADDR_OFFSET, 32'(src_w * 4));
    reg_write(apb_reg_pkg::DST_ADDR_OFFSET, 32'(dst_w * 4));
    reg_write(apb_reg_pkg::SIZE_OFFSET, 32'(len));
    reg_write(apb_reg_pkg::CTRL_OFFSET, START_MASK);
    finished = 1'b0;
    fork
      begin
        do begin
          apb_xfer(1'b0, apb_reg_pkg::STATUS_OFFSET, 32'd0, status, e);
        end while (status[apb_reg_pkg::BUSY_BIT]);
        finished = 1'b1;
      end
      begin
        // Upper words stay clear of every copy region
        while (!finished) begin
          w = NUM_WORDS - 32 + int'($urandom_range(0, 31));
          if ($urandom % 2 == 1) begin
            v = $urandom;
            obi_access(1'b1, 32'(w * 4), v, r);
            shadow[w] = v;
          end else begin
            obi_access(1'b0, 32'(w * 4), 32'd0, r);
            expect_value("ext_rdata_o", shadow[w], r);
          end
        end
      end
    join
    expect_value("prdata_o (STATUS)", DONE_MASK, status);
    expect_value("intr_o", 32'd0, 32'(intr_o));
    reg_write(apb_reg_pkg::STATUS_OFFSET, DONE_MASK);
    verify_copy(src_w, dst_w, len);
  endtask

  initial begin : main
    logic [31:0] d;
    logic [31:0] v;
    logic        e;
    int          len;
    int          a;
    int          b;
    int          rises_before;
    void'($urandom(1634));
    errors      = 0;
    checks      = 0;
    reset_i     = 1'b1;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = '0;
    pwdata_i    = '0;
    ext_req_i   = 1'b0;
    ext_we_i    = 1'b0;
    ext_addr_i  = '0;
    ext_wdata_i = '0;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);

    expect_value("intr_o", 32'd0, 32'(intr_o));
    expect_value("ext_gnt_o", 32'd0, 32'(ext_gnt_o));
    expect_value("ext_rvalid_o", 32'd0, 32'(ext_rvalid_o));
    reg_check(apb_reg_pkg::STATUS_OFFSET, 32'd0, "prdata_o (STATUS)");

    v = $urandom;
    reg_write(apb_reg_pkg::SRC_ADDR_OFFSET, v);
    reg_check(apb_reg_pkg::SRC_ADDR_OFFSET, v, "prdata_o (SRC_ADDR)");
    v = $urandom;
    reg_write(apb_reg_pkg::DST_ADDR_OFFSET, v);
    reg_check(apb_reg_pkg::DST_ADDR_OFFSET, v, "prdata_o (DST_ADDR)");
    v = $urandom;
    reg_write(apb_reg_pkg::SIZE_OFFSET, v);
    reg_check(apb_reg_pkg::SIZE_OFFSET, v & SIZE_MASK, "prdata_o (SIZE)");
    v = $urandom & ~START_MASK;
    reg_write(apb_reg_pkg::CTRL_OFFSET, v);
    reg_check(apb_reg_pkg::CTRL_OFFSET, v & INTR_EN_MASK, "prdata_o (CTRL)");

    // Zero-length copy, START itself never reads back
    reg_write(apb_reg_pkg::SIZE_OFFSET, 32'd0);
    reg_write(apb_reg_pkg::CTRL_OFFSET, START_MASK);
    reg_check(apb_reg_pkg::CTRL_OFFSET, 32'd0, "prdata_o (CTRL)");
    reg_check(apb_reg_pkg::STATUS_OFFSET, DONE_MASK, "prdata_o (STATUS)");
    reg_write(apb_reg_pkg::STATUS_OFFSET, DONE_MASK);
    reg_check(apb_reg_pkg::STATUS_OFFSET, 32'd0, "prdata_o (STATUS)");

    for (int off = 'h14; off < 32; off += 4) begin
      apb_xfer(off[2], 5'(off), 32'(off), d, e);
      expect_value("pslverr_o", 32'd1, 32'(e));
    end

    for (int w = 0; w < NUM_WORDS; w++) begin
      v = $urandom;
      obi_access(1'b1, 32'(w * 4), v, d);
      shadow[w] = v;
    end
    for (int w = 0; w < NUM_WORDS; w++) begin
      obi_access(1'b0, 32'(w * 4), 32'd0, d);
      expect_value("ext_rdata_o", shadow[w], d);
    end

    // Lower half for source, upper half for destination, swapped on odd runs
    for (int k = 0; k < 5; k++) begin
      len = int'($urandom_range(0, MAX_LEN));
      a   = int'($urandom_range(0, 48 - len));
      b   = 48 + int'($urandom_range(0, 48 - len));
      if (k % 2 == 1) begin
        run_copy(b, a, len);
      end else begin
        run_copy(a, b, len);
      end
    end

    len = 8;
    a   = int'($urandom_range(0, 40));
    b   = 48 + int'($urandom_range(0, 40));
    rises_before = intr_rises;
    reg_write(apb_reg_pkg::SRC_ADDR_OFFSET, 32'(a * 4));
    reg_write(apb_reg_pkg::DST_ADDR_OFFSET, 32'(b * 4));
    reg_write(apb_reg_pkg::SIZE_OFFSET, 32'(len));
    reg_write(apb_reg_pkg::CTRL_OFFSET, INTR_EN_MASK | START_MASK);
    // Lands while the first copy still runs
    reg_write(apb_reg_pkg::CTRL_OFFSET, INTR_EN_MASK | START_MASK);
    reg_check(apb_reg_pkg::STATUS_OFFSET, BUSY_MASK, "prdata_o (STATUS)");
    do @(posedge clk_i); while (!intr_o);
    reg_check(apb_reg_pkg::STATUS_OFFSET, DONE_MASK, "prdata_o (STATUS)");
    expect_value("intr_o", 32'd1, 32'(intr_o));
    reg_write(apb_reg_pkg::STATUS_OFFSET, DONE_MASK);
    reg_check(apb_reg_pkg::STATUS_OFFSET, 32'd0, "prdata_o (STATUS)");
    expect_value("intr_o", 32'd0, 32'(intr_o));
    expect_value("intr_o rises", 32'(rises_before + 1), 32'(intr_rises));
    reg_write(apb_reg_pkg::CTRL_OFFSET, 32'd0);
    verify_copy(a, b, len);

    repeat (2) @(posedge clk_i);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== build.f ====
source/apb_reg_pkg.sv
source/obi_mem_pkg.sv
source/memcopy_regs.sv
source/memcopy_engine.sv
source/obi_arbiter.sv
source/slow_memory.sv
source/ext_device_top.sv
sim/ext_device_assertions.sv
sim/ext_device_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the external device testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module ext_device_tb -Mdir obj_dir -o ext_device_sim > build.log 2>&1 \
  || { cat build.log; echo "FAIL: build"; exit 1; }

./obj_dir/ext_device_sim > sim.log 2>&1
cat sim.log

grep -qx "Done: no errors" sim.log && echo "PASS" && exit 0 \
  || { echo "FAIL"; exit 1; }
